// ==== build.f ====
icache_pkg.sv
icache_request_ctrl.sv
icache_array.sv
icache_prefetch_buffer.sv
icache_top.sv
icache_tb_memory.sv
icache_tb.sv

// ==== icache_array.sv ====
`timescale 1ns/100ps

module icache_array import icache_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic [addr_width-1:0] lookup_addr,
	output logic hit,
	output logic [word_width-1:0] hit_data,
	input logic miss_record,
	input logic [resp_width-1:0] miss_resp,
	input logic [addr_width-1:0] miss_addr,
	input logic [resp_width-1:0] mem_tag,
	input logic [word_width-1:0] mem_data
);

	logic [num_lines-1:0] line_valid;
	logic [tag_bits-1:0] line_tag [num_lines];
	logic [word_width-1:0] line_data [num_lines];

	// outstanding misses, indexed by response number
	logic [num_resp-1:0] slot_busy;
	logic [index_bits-1:0] slot_index [num_resp];
	logic [tag_bits-1:0] slot_tag [num_resp];

	logic [index_bits-1:0] lookup_index;
	logic [tag_bits-1:0] lookup_tag;
	logic [index_bits-1:0] fill_index;
	logic fill;

	assign lookup_index = lookup_addr[offset_bits +: index_bits];
	assign lookup_tag = lookup_addr[addr_width-1 -: tag_bits];

	assign hit = line_valid[lookup_index] && (line_tag[lookup_index] == lookup_tag);
	assign hit_data = line_data[lookup_index];

	assign fill = mem_tag != '0;
	assign fill_index = slot_index[mem_tag];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			line_valid <= '0;
			slot_busy <= '0;
		end
		else
		begin
			if (fill)
			begin
				line_valid[fill_index] <= 1'b1;
				slot_busy[mem_tag] <= 1'b0;
			end
			// a number freed this cycle may be handed out again right away
			if (miss_record)
				slot_busy[miss_resp] <= 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (fill)
		begin
			line_tag[fill_index] <= slot_tag[mem_tag];
			line_data[fill_index] <= mem_data;
		end
		if (miss_record)
		begin
			slot_index[miss_resp] <= miss_addr[offset_bits +: index_bits];
			slot_tag[miss_resp] <= miss_addr[addr_width-1 -: tag_bits];
		end
	end

	a_tag_has_slot: assert property
	(
		@(posedge clock) disable iff (reset)
		fill |-> slot_busy[mem_tag]
	)
	else $error("memory returned tag %0d with no outstanding miss", mem_tag);

endmodule

// ==== icache_pkg.sv ====
package icache_pkg;

	// fetch and memory bus widths
	localparam int addr_width = 64;
	localparam int word_width = 64;

	// address split: tag | index | byte offset
	localparam int offset_bits = 3;
	localparam int index_bits = 5;
	localparam int tag_bits = addr_width - index_bits - offset_bits;
	localparam int num_lines = 1 << index_bits;

	// tagged memory, response 0 means none
	localparam int resp_width = 4;
	localparam int num_resp = 16;

	// prefetch buffer, pointers carry one wrap bit
	localparam int buf_depth = 16;
	localparam int buf_ptr_bits = 5;

	typedef enum logic [1:0]
	{
		bus_none = 2'h0,
		bus_load = 2'h1
	} bus_command_t;

endpackage

// ==== icache_prefetch_buffer.sv ====
`timescale 1ns/100ps

module icache_prefetch_buffer import icache_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic flush,
	input logic push,
	input logic [addr_width-1:0] push_addr,
	input logic push_ready_word,
	input logic [word_width-1:0] push_data,
	input logic [resp_width-1:0] push_resp,
	input logic [resp_width-1:0] mem_tag,
	input logic [word_width-1:0] mem_data,
	output logic buffer_full,
	output logic out_valid,
	input logic out_ready,
	output logic [word_width-1:0] out_data,
	output logic [addr_width-1:0] out_addr
);

	logic [addr_width-1:0] entry_addr [buf_depth];
	logic [word_width-1:0] entry_data [buf_depth];
	logic [resp_width-1:0] entry_resp [buf_depth];
	logic [buf_depth-1:0] entry_used;
	logic [buf_depth-1:0] entry_done;

	logic [buf_ptr_bits-1:0] head;
	logic [buf_ptr_bits-1:0] tail;
	logic [buf_ptr_bits-1:0] count;
	logic [buf_ptr_bits-2:0] head_idx;
	logic [buf_ptr_bits-2:0] tail_idx;
	logic [buf_depth-1:0] tag_match;
	logic pop;

	assign head_idx = head[buf_ptr_bits-2:0];
	assign tail_idx = tail[buf_ptr_bits-2:0];
	assign count = tail - head;

	assign buffer_full = count == buf_ptr_bits'(buf_depth);

	// nothing leaves in a flush cycle, the whole queue is dropped
	assign out_valid = entry_used[head_idx] && entry_done[head_idx] && !flush;
	assign out_data = entry_data[head_idx];
	assign out_addr = entry_addr[head_idx];
	assign pop = out_valid && out_ready;

	// every waiting entry with the returning number completes together
	always_comb
	begin
		tag_match = '0;
		for (int i = 0; i < buf_depth; i++)
		begin
			if ((mem_tag != '0) && entry_used[i] && !entry_done[i] && (entry_resp[i] == mem_tag))
				tag_match[i] = 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset || flush)
		begin
			head <= '0;
			tail <= '0;
			entry_used <= '0;
			entry_done <= '0;
		end
		else
		begin
			entry_done <= entry_done | tag_match;
			if (pop)
			begin
				entry_used[head_idx] <= 1'b0;
				entry_done[head_idx] <= 1'b0;
				head <= head + 1'b1;
			end
			if (push)
			begin
				entry_used[tail_idx] <= 1'b1;
				entry_done[tail_idx] <= push_ready_word;
				tail <= tail + 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		for (int i = 0; i < buf_depth; i++)
		begin
			if (tag_match[i])
				entry_data[i] <= mem_data;
		end
		if (push)
		begin
			entry_addr[tail_idx] <= push_addr;
			entry_data[tail_idx] <= push_data;
			entry_resp[tail_idx] <= push_resp;
		end
	end

	a_ptr_span: assert property
	(
		@(posedge clock) disable iff (reset)
		count <= buf_ptr_bits'(buf_depth)
	)
	else $error("buffer pointers %0d apart", count);

endmodule

// ==== icache_request_ctrl.sv ====
`timescale 1ns/100ps

module icache_request_ctrl import icache_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic fetch_valid,
	input logic [addr_width-1:0] fetch_addr,
	input logic flush,
	output logic fetch_ready,
	input logic hit,
	input logic [word_width-1:0] hit_data,
	input logic buffer_full,
	input logic [resp_width-1:0] mem_response,
	output bus_command_t mem_command,
	output logic [addr_width-1:0] mem_addr,
	output logic miss_record,
	output logic [resp_width-1:0] miss_resp,
	output logic push,
	output logic [addr_width-1:0] push_addr,
	output logic push_ready_word,
	output logic [word_width-1:0] push_data,
	output logic [resp_width-1:0] push_resp
);

	logic miss_issue;
	logic miss_accept;
	logic hit_accept;

	// load goes out only for a live miss with room left in the buffer
	assign miss_issue = fetch_valid && !hit && !buffer_full && !flush;

	// memory answers combinationally in the same cycle
	assign miss_accept = miss_issue && (mem_response != '0);
	assign hit_accept = hit && !buffer_full && !flush;

	assign fetch_ready = hit_accept || miss_accept;

	assign mem_command = miss_issue ? bus_load : bus_none;
	assign mem_addr = {fetch_addr[addr_width-1:offset_bits], {offset_bits{1'b0}}};

	assign push = fetch_valid && fetch_ready;
	assign push_addr = fetch_addr;
	assign push_ready_word = hit;
	assign push_data = hit_data;
	assign push_resp = mem_response;

	// the array needs the number to route the return into the right line
	assign miss_record = push && !hit;
	assign miss_resp = mem_response;

	a_no_push_when_full: assert property
	(
		@(posedge clock) disable iff (reset)
		buffer_full |-> !push
	)
	else $error("buffer push while full");

	a_no_load_in_flush: assert property
	(
		@(posedge clock) disable iff (reset)
		flush |-> (mem_command == bus_none)
	)
	else $error("memory load issued during flush");

endmodule

// ==== icache_tb.sv ====
`timescale 1ns/100ps

module icache_tb import icache_pkg::*;
();

	localparam int clock_period = 8;
	localparam int num_fetches = 2000;
	localparam int pool_size = 48;
	localparam int t_reset = 0;
	localparam int t_order = 1;
	localparam int t_hit = 2;
	localparam int t_back = 3;
	localparam int t_busy = 4;
	localparam int t_flush = 5;

	logic clock;
	logic reset;
	logic fetch_valid;
	logic [addr_width-1:0] fetch_addr;
	logic fetch_ready;
	logic flush;
	bus_command_t mem_command;
	logic [addr_width-1:0] mem_addr;
	logic [resp_width-1:0] mem_response;
	logic [resp_width-1:0] mem_tag;
	logic [word_width-1:0] mem_data;
	logic out_valid;
	logic out_ready;
	logic [word_width-1:0] out_data;
	logic [addr_width-1:0] out_addr;

	integer seed;
	logic [addr_width-1:0] pool [pool_size];
	logic [addr_width-1:0] expected [$];
	logic [addr_width-1:0] load_addr [num_resp];
	logic [num_lines-1:0] shadow_valid;
	logic [addr_width-1:0] shadow_addr [num_lines];
	int accepted;
	int checks [6];
	int errors [6];
	string names [6];
	logic stall;
	logic flushed;

	icache_top icache_top_inst
	(
		.clock(clock),
		.reset(reset),
		.fetch_valid(fetch_valid),
		.fetch_addr(fetch_addr),
		.fetch_ready(fetch_ready),
		.flush(flush),
		.mem_command(mem_command),
		.mem_addr(mem_addr),
		.mem_response(mem_response),
		.mem_tag(mem_tag),
		.mem_data(mem_data),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data),
		.out_addr(out_addr)
	);

	icache_tb_memory memory_inst
	(
		.clock(clock),
		.reset(reset),
		.mem_command(mem_command),
		.mem_addr(mem_addr),
		.mem_response(mem_response),
		.mem_tag(mem_tag),
		.mem_data(mem_data)
	);

	function automatic logic [word_width-1:0] memory_word(logic [addr_width-1:0] addr);
		return {~addr[31:0], addr[31:0]};
	endfunction

	function automatic logic shadow_hit(logic [addr_width-1:0] addr);
		logic [index_bits-1:0] idx;
		idx = addr[offset_bits +: index_bits];
		return shadow_valid[idx] && (shadow_addr[idx] == addr);
	endfunction

	task automatic log_error(int kind, string msg);
		errors[kind]++;
		$display("** Error at %0t ns: %s", $time, msg);
	endtask

	task automatic print_result(int kind);
		$display("%s: %0d checks, %0d errors", names[kind], checks[kind], errors[kind]);
	endtask

	initial
	begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	// reference model, sampled mid-cycle where everything has settled
	always @(negedge clock)
	begin
		logic [index_bits-1:0] fill_index;
		if (!reset)
		begin
			if (flushed)
			begin
				checks[t_flush]++;
				if (out_valid)
					log_error(t_flush, "out_valid high in the cycle after a flush");
			end
			flushed = flush;
			if (out_valid && out_ready)
			begin
				checks[t_order]++;
				if (expected.size() == 0)
					log_error(t_order, $sformatf("output %h with no fetch pending", out_addr));
				else
				begin
					if (out_addr != expected[0])
						log_error(t_order, $sformatf("out_addr %h, expected %h", out_addr, expected[0]));
					if (out_data != memory_word(expected[0]))
						log_error(t_order, $sformatf("out_data %h for %h", out_data, expected[0]));
					void'(expected.pop_front());
				end
			end
			if (fetch_valid && shadow_hit(fetch_addr) && fetch_ready)
			begin
				checks[t_hit]++;
				if (mem_command != bus_none)
					log_error(t_hit, $sformatf("memory load on a hit to %h", fetch_addr));
			end
			if (fetch_valid && !shadow_hit(fetch_addr) && mem_response == '0)
			begin
				checks[t_busy]++;
				if (fetch_ready)
					log_error(t_busy, $sformatf("miss to %h accepted with no response", fetch_addr));
			end
			if (expected.size() == buf_depth)
			begin
				checks[t_back]++;
				if (fetch_ready)
					log_error(t_back, "fetch_ready high with 16 entries pending");
			end
			if (flush)
				expected.delete();
			else if (fetch_valid && fetch_ready)
			begin
				expected.push_back(fetch_addr);
				accepted++;
			end
			// return first, the number may be reused by a later load
			if (mem_tag != '0)
			begin
				fill_index = load_addr[mem_tag][offset_bits +: index_bits];
				shadow_valid[fill_index] = 1'b1;
				shadow_addr[fill_index] = load_addr[mem_tag];
			end
			if (mem_command == bus_load && mem_response != '0)
			begin
				checks[t_order]++;
				if (mem_addr != fetch_addr)
					log_error(t_order, $sformatf("mem_addr %h for fetch %h", mem_addr, fetch_addr));
				load_addr[mem_response] = fetch_addr;
			end
		end
	end

	initial
	begin
		int total_checks;
		int total_errors;
		seed = 32'h9ca2;
		names = '{"reset state", "ordered data", "hits skip memory",
			"back-pressure", "busy memory", "flush"};
		shadow_valid = '0;
		accepted = 0;
		flushed = 1'b0;
		stall = 1'b0;
		reset = 1'b1;
		fetch_valid = 1'b0;
		fetch_addr = '0;
		flush = 1'b0;
		out_ready = 1'b0;
		for (int i = 0; i < pool_size; i++)
			pool[i] = {$random(seed), $random(seed)} & ~64'h7;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		checks[t_reset] += 2;
		if (out_valid)
			log_error(t_reset, "out_valid high after reset");
		if (mem_command != bus_none)
			log_error(t_reset, "memory command active after reset");
		print_result(t_reset);
		while (accepted < num_fetches)
		begin
			@(posedge clock);
			// long stalls let the buffer fill up
			if ($unsigned($random(seed)) % 16 == 0)
				stall = ~stall;
			fetch_valid <= ($unsigned($random(seed)) % 4) != 0;
			fetch_addr <= pool[$unsigned($random(seed)) % pool_size];
			flush <= ($unsigned($random(seed)) % 64) == 0;
			out_ready <= !stall && (($unsigned($random(seed)) % 4) != 0);
		end
		@(posedge clock);
		fetch_valid <= 1'b0;
		flush <= 1'b0;
		out_ready <= 1'b1;
		while (expected.size() != 0)
			@(posedge clock);
		repeat (4) @(posedge clock);
		total_checks = checks[t_reset];
		total_errors = errors[t_reset];
		for (int k = t_order; k <= t_flush; k++)
		begin
			print_result(k);
			total_checks += checks[k];
			total_errors += errors[k];
		end
		$display("total: %0d checks, %0d errors", total_checks, total_errors);
		if (total_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	initial
	begin
		#(num_fetches * 40 * clock_period);
		$display("run timed out with %0d of %0d fetches accepted", accepted, num_fetches);
		$display("Regression failed");
		$finish;
	end

endmodule

// ==== icache_tb_memory.sv ====
`timescale 1ns/100ps

module icache_tb_memory import icache_pkg::*;
(
	input logic clock,
	input logic reset,
	input bus_command_t mem_command,
	input logic [addr_width-1:0] mem_addr,
	output logic [resp_width-1:0] mem_response,
	output logic [resp_width-1:0] mem_tag,
	output logic [word_width-1:0] mem_data
);

	integer seed;
	int cycle;
	logic refuse;
	logic [num_resp-1:0] busy;
	logic [num_resp-1:0] pending;
	int due [num_resp];
	logic [addr_width-1:0] load_addr [num_resp];

	initial
		seed = 32'h9ca2;

	// lowest free number, 0 when refusing or all numbers are out
	always_comb
	begin
		mem_response = '0;
		if (mem_command == bus_load && !refuse)
		begin
			for (int r = num_resp - 1; r >= 1; r--)
			begin
				if (!busy[r])
					mem_response = resp_width'(r);
			end
		end
	end

	always @(posedge clock)
	begin
		int ret;
		ret = 0;
		for (int r = num_resp - 1; r >= 1; r--)
		begin
			if (pending[r] && due[r] <= cycle)
				ret = r;
		end
		if (reset)
		begin
			cycle <= 0;
			refuse <= 1'b0;
			busy <= '0;
			pending <= '0;
			mem_tag <= '0;
			mem_data <= '0;
		end
		else
		begin
			cycle <= cycle + 1;
			refuse <= ($unsigned($random(seed)) % 4) == 0;
			// number stays out until its return cycle is over
			if (mem_tag != '0)
				busy[mem_tag] <= 1'b0;
			if (mem_response != '0)
			begin
				busy[mem_response] <= 1'b1;
				pending[mem_response] <= 1'b1;
				due[mem_response] <= cycle + 2 + $unsigned($random(seed)) % 19;
				load_addr[mem_response] <= mem_addr;
			end
			mem_tag <= resp_width'(ret);
			if (ret != 0)
			begin
				pending[ret] <= 1'b0;
				mem_data <= {~load_addr[ret][31:0], load_addr[ret][31:0]};
			end
		end
	end

endmodule

// ==== icache_top.sv ====
`timescale 1ns/100ps

module icache_top import icache_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic fetch_valid,
	input logic [addr_width-1:0] fetch_addr,
	output logic fetch_ready,
	input logic flush,
	output bus_command_t mem_command,
	output logic [addr_width-1:0] mem_addr,
	input logic [resp_width-1:0] mem_response,
	input logic [resp_width-1:0] mem_tag,
	input logic [word_width-1:0] mem_data,
	output logic out_valid,
	input logic out_ready,
	output logic [word_width-1:0] out_data,
	output logic [addr_width-1:0] out_addr
);

	logic hit;
	logic [word_width-1:0] hit_data;
	logic buffer_full;
	logic miss_record;
	logic [resp_width-1:0] miss_resp;
	logic push;
	logic [addr_width-1:0] push_addr;
	logic push_ready_word;
	logic [word_width-1:0] push_data;
	logic [resp_width-1:0] push_resp;

	icache_request_ctrl icache_request_ctrl_inst
	(
		.clock(clock),
		.reset(reset),
		.fetch_valid(fetch_valid),
		.fetch_addr(fetch_addr),
		.flush(flush),
		.fetch_ready(fetch_ready),
		.hit(hit),
		.hit_data(hit_data),
		.buffer_full(buffer_full),
		.mem_response(mem_response),
		.mem_command(mem_command),
		.mem_addr(mem_addr),
		.miss_record(miss_record),
		.miss_resp(miss_resp),
		.push(push),
		.push_addr(push_addr),
		.push_ready_word(push_ready_word),
		.push_data(push_data),
		.push_resp(push_resp)
	);

	// lookup on the presented fetch, misses recorded against the bus address
	icache_array icache_array_inst
	(
		.clock(clock),
		.reset(reset),
		.lookup_addr(fetch_addr),
		.hit(hit),
		.hit_data(hit_data),
		.miss_record(miss_record),
		.miss_resp(miss_resp),
		.miss_addr(mem_addr),
		.mem_tag(mem_tag),
		.mem_data(mem_data)
	);

	icache_prefetch_buffer icache_prefetch_buffer_inst
	(
		.clock(clock),
		.reset(reset),
		.flush(flush),
		.push(push),
		.push_addr(push_addr),
		.push_ready_word(push_ready_word),
		.push_data(push_data),
		.push_resp(push_resp),
		.mem_tag(mem_tag),
		.mem_data(mem_data),
		.buffer_full(buffer_full),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data),
		.out_addr(out_addr)
	);

endmodule
